// ==== mc_xbar.f ====
+incdir+hw
hw/mc_xbar_pkg.sv
hw/mc_input_fifo.sv
hw/mc_coord_translate.sv
hw/mc_fifo_delay.sv
hw/mc_xbar_fanout.sv
verif/mc_xbar_tb.sv

// ==== run_mc_xbar.sh ====
#!/bin/sh
# build the crossbar fanout testbench with Verilator, run it and check the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module mc_xbar_tb -f mc_xbar.f \
  -o mc_xbar_sim > build.log 2>&1 ||
  { cat build.log; echo "build failed"; exit 1; }

./obj_dir/mc_xbar_sim > sim.log 2>&1 ; cat sim.log

grep -q "^TEST PASSED$" sim.log && echo "simulation passed" ||
  { echo "simulation failed"; exit 1; }

// ==== verif/mc_xbar_tb.sv ====
// testbench for the crossbar fanout with random traffic, random back-pressure and a routing model
`default_nettype none

module mc_xbar_tb;
  import mc_xbar_pkg::*;

  // array size follows from the output index bases
  localparam int nx_lp            = south_base_lc - north_base_lc;
  localparam int ny_lp            = (north_base_lc - tile_base_lc) / nx_lp;
  localparam int x_w_lp           = 3;
  localparam int y_w_lp           = 3;
  localparam int ruche_lp         = 3;
  localparam int host_x_lp        = 0;
  localparam int host_y_lp        = 0;
  // default source position of the DUT
  localparam int src_x_lp         = 0;
  localparam int src_y_lp         = 2;
  localparam int num_pkts_lp      = 400;
  localparam int stim_timeout_lp  = 20000;
  localparam int drain_timeout_lp = 2000;

  logic                                       clk;
  logic                                       rst_n;
  logic                                       in_v;
  logic [packet_width_lc-1:0]                 in_packet;
  logic                                       in_ready;
  logic [num_out_lc-1:0]                      out_v;
  logic [num_out_lc-1:0][packet_width_lc-1:0] out_packet;
  logic [num_out_lc-1:0]                      out_yumi;

  int                         seed;
  int                         cyc;
  int                         sent;
  int                         received;
  int                         value_errors;
  int                         other_errors;
  bit                         saw_stall;
  logic [num_out_lc-1:0]      head_seen;
  logic [packet_width_lc-1:0] exp_pkt_q [num_out_lc][$];
  int                         exp_cyc_q [num_out_lc][$];

  mc_xbar_fanout u_dut (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .v_i      (in_v),
    .packet_i (in_packet),
    .ready_o  (in_ready),
    .v_o      (out_v),
    .packet_o (out_packet),
    .yumi_i   (out_yumi)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic int pick_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // destination mix of tiles, edge channels, host and arbitrary coordinates
  function automatic logic [packet_width_lc-1:0] make_packet();
    logic [packet_width_lc-1:0] pkt;
    int kind;
    int x;
    int y;
    pkt  = packet_width_lc'($random(seed));
    kind = pick_below(4);
    case (kind)
      0: begin
        x = nx_lp + pick_below(nx_lp);
        y = ny_lp + pick_below(ny_lp);
      end
      1: begin
        x = nx_lp + pick_below(nx_lp);
        y = (pick_below(2) == 0) ? (ny_lp - 1) : (2 * ny_lp);
      end
      2: begin
        x = host_x_lp;
        y = host_y_lp;
      end
      default: begin
        x = pick_below(1 << x_w_lp);
        y = pick_below(1 << y_w_lp);
      end
    endcase
    pkt[x_w_lp-1:0]       = x_w_lp'(x);
    pkt[x_w_lp +: y_w_lp] = y_w_lp'(y);
    return pkt;
  endfunction

  function automatic int expected_output(input logic [x_w_lp+y_w_lp-1:0] cord);
    int x;
    int y;
    x = int'(cord[x_w_lp-1:0]);
    y = int'(cord[x_w_lp +: y_w_lp]);
    if ((x >= nx_lp) && (x < 2 * nx_lp)) begin
      if ((y >= ny_lp) && (y < 2 * ny_lp)) return tile_base_lc + (x - nx_lp) + (y - ny_lp) * nx_lp;
      if (y == ny_lp - 1) return north_base_lc + (x - nx_lp);
      if (y == 2 * ny_lp) return south_base_lc + (x - nx_lp);
    end
    return 0;
  endfunction

  // ruche hop count from the source to the position behind output k
  function automatic int model_delay(input int k);
    int xd;
    int yd;
    int dx;
    int dy;
    int h;
    if (k == 0) begin
      xd = nx_lp;
      yd = ny_lp - 2;
    end else if (k >= south_base_lc) begin
      xd = nx_lp + k - south_base_lc;
      yd = 2 * ny_lp;
    end else if (k >= north_base_lc) begin
      xd = nx_lp + k - north_base_lc;
      yd = ny_lp - 1;
    end else begin
      xd = nx_lp + (k - tile_base_lc) % nx_lp;
      yd = ny_lp + (k - tile_base_lc) / nx_lp;
    end
    dx = (xd > src_x_lp) ? (xd - src_x_lp) : (src_x_lp - xd);
    dy = (yd > src_y_lp) ? (yd - src_y_lp) : (src_y_lp - yd);
    if ((dx != 0) && (dx % ruche_lp == 0)) h = (dx - ruche_lp) / ruche_lp + ruche_lp;
    else h = dx / ruche_lp + dx % ruche_lp;
    return (dy + h < 1) ? 1 : (dy + h);
  endfunction

  function automatic int pending_count();
    int n;
    n = 0;
    for (int k = 0; k < num_out_lc; k++) n += exp_pkt_q[k].size();
    return n;
  endfunction

  task automatic check_output(input int k);
    int lat;
    if (out_v[k]) begin
      if (exp_pkt_q[k].size() == 0) begin
        value_errors++;
        $display("ERR packet_o[%0d] unexpected packet %h", k, out_packet[k]);
      end else begin
        if (out_packet[k] !== exp_pkt_q[k][0]) begin
          value_errors++;
          $display("ERR packet_o[%0d] got %h exp %h", k, out_packet[k], exp_pkt_q[k][0]);
        end
        if (!head_seen[k]) begin
          head_seen[k] = 1'b1;
          lat = cyc - exp_cyc_q[k][0];
          if (lat < 1 + model_delay(k)) begin
            other_errors++;
            $display("output %0d went valid %0d cycles after acceptance, minimum is %0d",
                     k, lat, 1 + model_delay(k));
          end
        end
        if (out_yumi[k]) begin
          void'(exp_pkt_q[k].pop_front());
          void'(exp_cyc_q[k].pop_front());
          head_seen[k] = 1'b0;
          received++;
        end
      end
    end
  endtask

  // one clock edge: sample, check, then drive the next inputs
  task automatic step(input bit inject);
    logic [num_out_lc-1:0] next_yumi;
    int exp_k;
    int rate;
    @(posedge clk);
    cyc++;
    if (!in_ready) saw_stall = 1'b1;
    if (in_v && in_ready) begin
      exp_k = expected_output(in_packet[x_w_lp+y_w_lp-1:0]);
      exp_pkt_q[exp_k].push_back(in_packet);
      exp_cyc_q[exp_k].push_back(cyc);
      sent++;
    end
    for (int k = 0; k < num_out_lc; k++) check_output(k);
    // slow consumers every other 64-cycle window
    rate = (inject && ((cyc / 64) % 2 == 1)) ? 1 : 6;
    // a head seen but not taken stays valid, so yumi on it is safe
    for (int k = 0; k < num_out_lc; k++) begin
      next_yumi[k] = out_v[k] && !out_yumi[k] && (pick_below(8) < rate);
    end
    out_yumi <= next_yumi;
    if (!inject || (sent >= num_pkts_lp)) begin
      in_v <= 1'b0;
    end else if (!in_v || in_ready) begin
      in_v      <= (pick_below(4) != 0);
      in_packet <= make_packet();
    end
  endtask

  initial begin
    int wait_cnt;
    seed         = 32'hfc52_d013;
    cyc          = 0;
    sent         = 0;
    received     = 0;
    value_errors = 0;
    other_errors = 0;
    saw_stall    = 1'b0;
    head_seen    = '0;
    rst_n        = 1'b0;
    in_v         = 1'b0;
    in_packet    = '0;
    out_yumi     = '0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (out_v !== '0) begin
      value_errors++;
      $display("ERR v_o after reset got %h exp %h", out_v, {num_out_lc{1'b0}});
    end
    if (in_ready !== 1'b1) begin
      value_errors++;
      $display("ERR ready_o after reset got %h exp %h", in_ready, 1'b1);
    end
    wait_cnt = 0;
    while ((sent < num_pkts_lp) && (wait_cnt < stim_timeout_lp)) begin
      step(1'b1);
      wait_cnt++;
    end
    if (sent < num_pkts_lp) begin
      other_errors++;
      $display("timeout with only %0d of %0d packets accepted", sent, num_pkts_lp);
    end
    wait_cnt = 0;
    while ((pending_count() != 0) && (wait_cnt < drain_timeout_lp)) begin
      step(1'b0);
      wait_cnt++;
    end
    if (pending_count() != 0) begin
      other_errors++;
      $display("timeout with %0d packets still inside the DUT", pending_count());
    end
    // quiet tail catches duplicated packets
    repeat (50) step(1'b0);
    if (!saw_stall) begin
      other_errors++;
      $display("ready_o never dropped while outputs were stalled");
    end
    $display("%0d packets sent, %0d received, %0d value errors, %0d other errors",
             sent, received, value_errors, other_errors);
    if ((value_errors == 0) && (other_errors == 0)) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/mc_xbar_fanout.sv ====
// crossbar fanout top with input FIFO, destination decode, steering and per-output delay FIFOs
`default_nettype none

`include "mc_xbar_params.svh"

module mc_xbar_fanout #(
  parameter int global_x_p = 0,
  parameter int global_y_p = 2
) (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_n_i,

  input  wire logic                                   v_i,
  input  wire logic [mc_xbar_pkg::packet_width_lc-1:0] packet_i,
  output logic                                        ready_o,

  output logic      [mc_xbar_pkg::num_out_lc-1:0]     v_o,
  output logic      [mc_xbar_pkg::num_out_lc-1:0][mc_xbar_pkg::packet_width_lc-1:0] packet_o,
  input  wire logic [mc_xbar_pkg::num_out_lc-1:0]     yumi_i
);
  import mc_xbar_pkg::*;

  localparam int nx_lp     = `MC_NUM_TILES_X;
  localparam int ny_lp     = `MC_NUM_TILES_Y;
  localparam int cord_w_lp = `MC_X_CORD_WIDTH + `MC_Y_CORD_WIDTH;

  logic                       in_v;
  logic                       in_yumi;
  logic [packet_width_lc-1:0] in_packet;
  logic [num_out_lc-1:0]      sel_one_hot;
  logic [num_out_lc-1:0]      fifo_v;
  logic [num_out_lc-1:0]      fifo_ready;

  mc_input_fifo u_in_fifo (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .v_i     (v_i),
    .data_i  (packet_i),
    .ready_o (ready_o),
    .v_o     (in_v),
    .data_o  (in_packet),
    .yumi_i  (in_yumi)
  );

  mc_coord_translate u_translate (
    .cord_i        (in_packet[cord_w_lp-1:0]),
    .sel_one_hot_o (sel_one_hot)
  );

  // head moves on only when its own output has room
  assign in_yumi = in_v & (|(sel_one_hot & fifo_ready));
  assign fifo_v  = sel_one_hot & {num_out_lc{in_yumi}};

  for (genvar k = 0; k < num_out_lc; k++) begin : g_out
    // column of this output, unused for the host
    localparam int col_lp = (k >= south_base_lc) ? (k - south_base_lc)
                          : (k >= north_base_lc) ? (k - north_base_lc)
                          : (k >= tile_base_lc)  ? ((k - tile_base_lc) % nx_lp)
                          : 0;
    localparam int dst_x_lp = (k == 0) ? nx_lp : (nx_lp + col_lp);
    localparam int dst_y_lp = (k == 0)              ? (ny_lp - 2)
                            : (k >= south_base_lc)  ? (2 * ny_lp)
                            : (k >= north_base_lc)  ? (ny_lp - 1)
                            : (ny_lp + ((k - tile_base_lc) / nx_lp));
    localparam int delay_lp = route_delay(global_x_p, global_y_p, dst_x_lp, dst_y_lp);

    mc_fifo_delay #(
      .delay_p (delay_lp)
    ) u_delay (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .v_i     (fifo_v[k]),
      .data_i  (in_packet),
      .ready_o (fifo_ready[k]),
      .v_o     (v_o[k]),
      .data_o  (packet_o[k]),
      .yumi_i  (yumi_i[k])
    );
  end

  // a stalled head is not dropped or replaced before its output takes it
  a_head_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                (in_v && !in_yumi) |=> (in_v && $stable(in_packet)))
    else $error("mc_xbar_fanout: input head changed while stalled");

endmodule

`default_nettype wire

// ==== hw/mc_fifo_delay.sv ====
// delay FIFO, the head shows up only delay_p cycles after it was enqueued
`default_nettype none

`include "mc_xbar_params.svh"

module mc_fifo_delay #(
  parameter int delay_p = 1,
  parameter int els_p   = `MC_FIFO_ELS
) (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_n_i,

  input  wire logic                                   v_i,
  input  wire logic [mc_xbar_pkg::packet_width_lc-1:0] data_i,
  output logic                                        ready_o,

  output logic                                        v_o,
  output logic      [mc_xbar_pkg::packet_width_lc-1:0] data_o,
  input  wire logic                                   yumi_i
);
  import mc_xbar_pkg::*;

  localparam int ptr_w_lp   = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w_lp   = $clog2(els_p + 1);
  // one spare bit so an entry's age passes delay_p before it wraps
  localparam int stamp_w_lp = $clog2(delay_p + 1) + 1;

  logic [packet_width_lc-1:0] mem_q   [els_p];
  logic [stamp_w_lp-1:0]      stamp_q [els_p];
  logic [els_p-1:0]           ripe_q;
  logic [els_p-1:0]           ripe_d;
  logic [stamp_w_lp-1:0]      cycle_q;
  logic [ptr_w_lp-1:0]        rd_ptr_q;
  logic [ptr_w_lp-1:0]        wr_ptr_q;
  logic [cnt_w_lp-1:0]        count_q;
  logic [stamp_w_lp-1:0]      head_age;
  logic                       head_ripe;
  logic                       wr_en;
  logic                       rd_en;

  assign head_age  = cycle_q - stamp_q[rd_ptr_q];
  assign head_ripe = ripe_q[rd_ptr_q] | (head_age >= stamp_w_lp'(delay_p));

  assign ready_o = (count_q != cnt_w_lp'(els_p));
  assign v_o     = (count_q != '0) & head_ripe;
  assign data_o  = mem_q[rd_ptr_q];
  assign wr_en   = v_i & ready_o;
  assign rd_en   = yumi_i & v_o;

  // ripe is sticky, so a head that waits long keeps v_o up across a counter wrap
  always_comb begin
    for (int i = 0; i < els_p; i++) begin
      ripe_d[i] = ripe_q[i] | ((cycle_q - stamp_q[i]) >= stamp_w_lp'(delay_p));
    end
    if (wr_en) begin
      ripe_d[wr_ptr_q] = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cycle_q  <= '0;
      ripe_q   <= '0;
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      cycle_q <= cycle_q + 1'b1;
      ripe_q  <= ripe_d;
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w_lp'(els_p - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w_lp'(els_p - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // packet and its enqueue stamp
  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q]   <= data_i;
      stamp_q[wr_ptr_q] <= cycle_q;
    end
  end

  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i) yumi_i |-> v_o)
    else $error("mc_fifo_delay: yumi_i while v_o is low");

  // the steering logic must only write here when this FIFO has room
  a_no_write_full: assert property (@(posedge clk_i) disable iff (!rst_n_i) v_i |-> ready_o)
    else $error("mc_fifo_delay: write while full");

endmodule

`default_nettype wire

// ==== hw/mc_coord_translate.sv ====
// destination coordinate decoder to a one-hot output select, host as the default
`default_nettype none

`include "mc_xbar_params.svh"

module mc_coord_translate (
  input  wire logic [`MC_X_CORD_WIDTH+`MC_Y_CORD_WIDTH-1:0] cord_i,
  output logic      [mc_xbar_pkg::num_out_lc-1:0]          sel_one_hot_o
);
  import mc_xbar_pkg::*;

  localparam int nx_lp  = `MC_NUM_TILES_X;
  localparam int ny_lp  = `MC_NUM_TILES_Y;
  localparam int x_w_lp = `MC_X_CORD_WIDTH;
  localparam int y_w_lp = `MC_Y_CORD_WIDTH;

  logic [x_w_lp-1:0]     x_cord;
  logic [y_w_lp-1:0]     y_cord;
  logic [num_out_lc-1:0] sel_map;

  assign x_cord   = cord_i[x_w_lp-1:0];
  assign y_cord   = cord_i[x_w_lp +: y_w_lp];

  // tile columns sit at x in [nx, 2nx)
  always_comb begin
    sel_map = '0;
    for (int c = 0; c < nx_lp; c++) begin
      if (int'(x_cord) == nx_lp + c) begin
        for (int r = 0; r < ny_lp; r++) begin
          if (int'(y_cord) == ny_lp + r) begin
            sel_map[tile_base_lc + c + (r * nx_lp)] = 1'b1;
          end
        end
        // edge channels, one row above and one row below the array
        if (int'(y_cord) == ny_lp - 1) begin
          sel_map[north_base_lc + c] = 1'b1;
        end
        if (int'(y_cord) == 2 * ny_lp) begin
          sel_map[south_base_lc + c] = 1'b1;
        end
      end
    end
  end

  // anything unmapped goes to the host
  assign sel_one_hot_o = (sel_map == '0) ? num_out_lc'(1) : sel_map;

  always_comb begin
    a_sel_one_hot: assert final ($onehot(sel_one_hot_o))
      else $error("mc_coord_translate: select %b is not one-hot", sel_one_hot_o);
  end

endmodule

`default_nettype wire

// ==== hw/mc_input_fifo.sv ====
// input packet FIFO, valid/ready on the write side and valid/yumi on the read side
`default_nettype none

`include "mc_xbar_params.svh"

module mc_input_fifo #(
  parameter int els_p = `MC_INPUT_FIFO_ELS
) (
  input  wire logic                                   clk_i,
  input  wire logic                                   rst_n_i,

  input  wire logic                                   v_i,
  input  wire logic [mc_xbar_pkg::packet_width_lc-1:0] data_i,
  output logic                                        ready_o,

  output logic                                        v_o,
  output logic      [mc_xbar_pkg::packet_width_lc-1:0] data_o,
  input  wire logic                                   yumi_i
);
  import mc_xbar_pkg::*;

  localparam int ptr_w_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_w_lp = $clog2(els_p + 1);

  logic [packet_width_lc-1:0] mem_q [els_p];
  logic [ptr_w_lp-1:0]        rd_ptr_q;
  logic [ptr_w_lp-1:0]        wr_ptr_q;
  logic [cnt_w_lp-1:0]        count_q;
  logic                       wr_en;
  logic                       rd_en;

  // no bypass, a full FIFO stays not ready even while the head leaves
  assign ready_o = (count_q != cnt_w_lp'(els_p));
  assign v_o     = (count_q != '0);
  assign data_o  = mem_q[rd_ptr_q];
  assign wr_en   = v_i & ready_o;
  assign rd_en   = yumi_i & v_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= (wr_ptr_q == ptr_w_lp'(els_p - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= (rd_ptr_q == ptr_w_lp'(els_p - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // the consumer may only take a head that is there
  a_yumi_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i) yumi_i |-> v_o)
    else $error("mc_input_fifo: yumi_i while v_o is low");

endmodule

`default_nettype wire

// ==== hw/mc_xbar_pkg.sv ====
// package with output count, packet width, output index bases and the ruche route delay function
`default_nettype none

`include "mc_xbar_params.svh"

package mc_xbar_pkg;

  // host, then tiles row by row, then north and south edge channels
  localparam int num_out_lc = 1 + (`MC_NUM_TILES_X * `MC_NUM_TILES_Y) + (2 * `MC_NUM_TILES_X);

  localparam int packet_width_lc = `MC_ADDR_WIDTH + `MC_DATA_WIDTH
                                 + `MC_X_CORD_WIDTH + `MC_Y_CORD_WIDTH;

  localparam int tile_base_lc  = 1;
  localparam int north_base_lc = tile_base_lc + (`MC_NUM_TILES_X * `MC_NUM_TILES_Y);
  localparam int south_base_lc = north_base_lc + `MC_NUM_TILES_X;

  // cycles a ruche network needs between two positions, never below 1
  function automatic int route_delay(input int src_x, input int src_y,
                                     input int dst_x, input int dst_y);
    int dx;
    int dy;
    int hx;
    int total;
    dx = (dst_x > src_x) ? (dst_x - src_x) : (src_x - dst_x);
    dy = (dst_y > src_y) ? (dst_y - src_y) : (src_y - dst_y);
    // an exact multiple ends on a ruche link, so the last link counts as its length
    if ((dx != 0) && ((dx % `MC_RUCHE_FACTOR_X) == 0)) begin
      hx = ((dx - `MC_RUCHE_FACTOR_X) / `MC_RUCHE_FACTOR_X) + `MC_RUCHE_FACTOR_X;
    end else begin
      hx = (dx / `MC_RUCHE_FACTOR_X) + (dx % `MC_RUCHE_FACTOR_X);
    end
    total = dy + hx;
    if (total < 1) begin
      total = 1;
    end
    return total;
  endfunction

endpackage

`default_nettype wire

// ==== hw/mc_xbar_params.svh ====
// array size, coordinate widths, packet field widths and FIFO depths of the crossbar fanout
`ifndef MC_XBAR_PARAMS_SVH
`define MC_XBAR_PARAMS_SVH

// tile array
`define MC_NUM_TILES_X 2
`define MC_NUM_TILES_Y 2

// coordinate fields, x in the low bits and y right above it
`define MC_X_CORD_WIDTH 3
`define MC_Y_CORD_WIDTH 3

// packet payload
`define MC_ADDR_WIDTH 8
`define MC_DATA_WIDTH 16

// host position
`define MC_HOST_X_CORD 0
`define MC_HOST_Y_CORD 0

// hops spanned by one horizontal ruche link
`define MC_RUCHE_FACTOR_X 3

// buffer depths
`define MC_INPUT_FIFO_ELS 2
`define MC_FIFO_ELS 4

`endif
